// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_decode_stage
FILELIST   := vlog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/decode_pkg.sv
package decode_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // basic types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] word_t;

  // alu function select bit positions.
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;
  localparam int ALU_W    = 12;

  typedef logic [ALU_W-1:0] alu_op_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcode encodings.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // major opcode, bits 31:26.
  localparam logic [5:0] OPC_ALU    = 6'h00;
  localparam logic [5:0] OPC_LU12I  = 6'h05;
  localparam logic [5:0] OPC_PCADDU = 6'h07;
  localparam logic [5:0] OPC_MEM    = 6'h0a;
  localparam logic [5:0] OPC_JIRL   = 6'h13;
  localparam logic [5:0] OPC_B      = 6'h14;
  localparam logic [5:0] OPC_BL     = 6'h15;
  localparam logic [5:0] OPC_BEQ    = 6'h16;
  localparam logic [5:0] OPC_BNE    = 6'h17;
  localparam logic [5:0] OPC_BLT    = 6'h18;
  localparam logic [5:0] OPC_BGE    = 6'h19;
  localparam logic [5:0] OPC_BLTU   = 6'h1a;
  localparam logic [5:0] OPC_BGEU   = 6'h1b;

  // minor opcode, bits 25:22.
  localparam logic [3:0] MIN_SLTI   = 4'h8;
  localparam logic [3:0] MIN_SLTUI  = 4'h9;
  localparam logic [3:0] MIN_ADDI   = 4'ha;
  localparam logic [3:0] MIN_ANDI   = 4'hd;
  localparam logic [3:0] MIN_ORI    = 4'he;
  localparam logic [3:0] MIN_XORI   = 4'hf;
  localparam logic [3:0] MIN_LD_W   = 4'h2;
  localparam logic [3:0] MIN_ST_W   = 4'h6;

  // full 3r opcode, bits 31:15. shift-immediate forms live here too.
  localparam logic [16:0] FN_ADD_W  = 17'h00020;
  localparam logic [16:0] FN_SUB_W  = 17'h00022;
  localparam logic [16:0] FN_SLT    = 17'h00024;
  localparam logic [16:0] FN_SLTU   = 17'h00025;
  localparam logic [16:0] FN_NOR    = 17'h00028;
  localparam logic [16:0] FN_AND    = 17'h00029;
  localparam logic [16:0] FN_OR     = 17'h0002a;
  localparam logic [16:0] FN_XOR    = 17'h0002b;
  localparam logic [16:0] FN_SLL_W  = 17'h0002e;
  localparam logic [16:0] FN_SRL_W  = 17'h0002f;
  localparam logic [16:0] FN_SRA_W  = 17'h00030;
  localparam logic [16:0] FN_SLLI_W = 17'h00081;
  localparam logic [16:0] FN_SRLI_W = 17'h00089;
  localparam logic [16:0] FN_SRAI_W = 17'h00091;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word views.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [16:0] opcode;
    reg_addr_t   rk;
    reg_addr_t   rj;
    reg_addr_t   rd;
  } r3_fmt_t;

  typedef struct packed {
    logic [5:0]  major;
    logic [3:0]  minor;
    logic [11:0] imm12;
    reg_addr_t   rj;
    reg_addr_t   rd;
  } ri_fmt_t;

  typedef union packed {
    r3_fmt_t r3;
    ri_fmt_t ri;
  } instr_word_u;

  typedef struct packed {
    logic        valid;
    logic        pred_jump;
    instr_word_u instr;
    word_t       pc;
  } fetch_slot_t;

  typedef struct packed {
    alu_op_t   alu_op;
    logic      may_jump;
    logic      use_rj_value;
    logic      use_less;
    logic      need_less;
    logic      use_zero;
    logic      need_zero;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      src2_is_4;
    logic      gr_we;
    logic      mem_we;
    logic      res_from_mem;
    reg_addr_t dest;
    word_t     imm;
    word_t     rj_value;
    word_t     rkd_value;
    word_t     pc;
    logic      pred_jump;
  } exe_op_t;

  // what issue logic needs to know about one slot.
  typedef struct packed {
    logic      writes_reg;
    reg_addr_t dest;
    logic      reads_rj;
    reg_addr_t rj;
    logic      reads_rkd;
    reg_addr_t rkd;
    logic      may_jump;
    logic      is_ls;
  } hazard_t;

endpackage

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import decode_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_slot_t fetch_slot0,
  input  fetch_slot_t fetch_slot1,
  output logic [1:0]  pop,
  output reg_addr_t   rf_raddr0,
  output reg_addr_t   rf_raddr1,
  output reg_addr_t   rf_raddr2,
  output reg_addr_t   rf_raddr3,
  input  word_t       rf_rdata0,
  input  word_t       rf_rdata1,
  input  word_t       rf_rdata2,
  input  word_t       rf_rdata3,
  output exe_op_t     exe_op0,
  output exe_op_t     exe_op1,
  output logic        exe_valid0,
  output logic        exe_valid1,
  input  logic        exe_ready,
  input  logic        flush
);

  exe_op_t op0;
  exe_op_t op1;
  hazard_t hazard0;
  hazard_t hazard1;
  logic    issue0;
  logic    issue1;

  // slot 0 uses read ports 0/1, slot 1 ports 2/3.
  instr_decoder u_dec0 (
    .slot    (fetch_slot0),
    .rdata_a (rf_rdata0),
    .rdata_b (rf_rdata1),
    .raddr_a (rf_raddr0),
    .raddr_b (rf_raddr1),
    .op      (op0),
    .hazard  (hazard0)
  );

  instr_decoder u_dec1 (
    .slot    (fetch_slot1),
    .rdata_a (rf_rdata2),
    .rdata_b (rf_rdata3),
    .raddr_a (rf_raddr2),
    .raddr_b (rf_raddr3),
    .op      (op1),
    .hazard  (hazard1)
  );

  issue_check u_issue (
    .hazard0     (hazard0),
    .hazard1     (hazard1),
    .slot0_valid (fetch_slot0.valid),
    .slot1_valid (fetch_slot1.valid),
    .exe_ready   (exe_ready),
    .issue0      (issue0),
    .issue1      (issue1),
    .pop         (pop)
  );

  issue_reg u_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .exe_ready  (exe_ready),
    .issue0     (issue0),
    .issue1     (issue1),
    .op0_in     (op0),
    .op1_in     (op1),
    .exe_op0    (exe_op0),
    .exe_op1    (exe_op1),
    .exe_valid0 (exe_valid0),
    .exe_valid1 (exe_valid1)
  );

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
  import decode_pkg::*;
(
  input  fetch_slot_t slot,
  input  word_t       rdata_a,
  input  word_t       rdata_b,
  output reg_addr_t   raddr_a,
  output reg_addr_t   raddr_b,
  output exe_op_t     op,
  output hazard_t     hazard
);

  instr_word_u ins;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;

  logic is_alu_grp;
  logic is_mem_grp;
  logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
  logic inst_nor, inst_and, inst_or, inst_xor;
  logic inst_sll_w, inst_srl_w, inst_sra_w;
  logic inst_slli_w, inst_srli_w, inst_srai_w;
  logic inst_addi_w, inst_slti, inst_sltui;
  logic inst_andi, inst_ori, inst_xori;
  logic inst_lu12i_w, inst_pcaddu;
  logic inst_ld_w, inst_st_w;
  logic inst_jirl, inst_b, inst_bl;
  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;

  logic is_cond_br;
  logic is_3r_reg;
  logic need_ui5, need_si12, need_ui12, need_si16, need_i20, need_si26;
  logic src_reg_is_rd;
  logic src1_is_pc, src2_is_imm, src2_is_4;
  logic gr_we;
  logic may_jump;
  alu_op_t alu_op;
  word_t   imm;

  assign ins = slot.instr;

  // offsets and upper immediate span several ri fields.
  assign i12 = ins.ri.imm12;
  assign i16 = {ins.ri.minor, ins.ri.imm12};
  assign i20 = {ins.ri.minor[2:0], ins.ri.imm12, ins.ri.rj};
  assign i26 = {ins.ri.rj, ins.ri.rd, ins.ri.minor, ins.ri.imm12};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction flags.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign is_alu_grp   = ins.ri.major == OPC_ALU;
  assign is_mem_grp   = ins.ri.major == OPC_MEM;

  assign inst_add_w   = ins.r3.opcode == FN_ADD_W;
  assign inst_sub_w   = ins.r3.opcode == FN_SUB_W;
  assign inst_slt     = ins.r3.opcode == FN_SLT;
  assign inst_sltu    = ins.r3.opcode == FN_SLTU;
  assign inst_nor     = ins.r3.opcode == FN_NOR;
  assign inst_and     = ins.r3.opcode == FN_AND;
  assign inst_or      = ins.r3.opcode == FN_OR;
  assign inst_xor     = ins.r3.opcode == FN_XOR;
  assign inst_sll_w   = ins.r3.opcode == FN_SLL_W;
  assign inst_srl_w   = ins.r3.opcode == FN_SRL_W;
  assign inst_sra_w   = ins.r3.opcode == FN_SRA_W;
  assign inst_slli_w  = ins.r3.opcode == FN_SLLI_W;
  assign inst_srli_w  = ins.r3.opcode == FN_SRLI_W;
  assign inst_srai_w  = ins.r3.opcode == FN_SRAI_W;

  assign inst_addi_w  = is_alu_grp && ins.ri.minor == MIN_ADDI;
  assign inst_slti    = is_alu_grp && ins.ri.minor == MIN_SLTI;
  assign inst_sltui   = is_alu_grp && ins.ri.minor == MIN_SLTUI;
  assign inst_andi    = is_alu_grp && ins.ri.minor == MIN_ANDI;
  assign inst_ori     = is_alu_grp && ins.ri.minor == MIN_ORI;
  assign inst_xori    = is_alu_grp && ins.ri.minor == MIN_XORI;
  assign inst_ld_w    = is_mem_grp && ins.ri.minor == MIN_LD_W;
  assign inst_st_w    = is_mem_grp && ins.ri.minor == MIN_ST_W;

  // bit 25 must be clear for the 20-bit immediate forms.
  assign inst_lu12i_w = ins.ri.major == OPC_LU12I && !ins.ri.minor[3];
  assign inst_pcaddu  = ins.ri.major == OPC_PCADDU && !ins.ri.minor[3];

  assign inst_jirl    = ins.ri.major == OPC_JIRL;
  assign inst_b       = ins.ri.major == OPC_B;
  assign inst_bl      = ins.ri.major == OPC_BL;
  assign inst_beq     = ins.ri.major == OPC_BEQ;
  assign inst_bne     = ins.ri.major == OPC_BNE;
  assign inst_blt     = ins.ri.major == OPC_BLT;
  assign inst_bge     = ins.ri.major == OPC_BGE;
  assign inst_bltu    = ins.ri.major == OPC_BLTU;
  assign inst_bgeu    = ins.ri.major == OPC_BGEU;

  assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign is_3r_reg  = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                    | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controls and immediate.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    alu_op           = '0;
    alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                     | inst_jirl | inst_bl | inst_pcaddu;
    alu_op[ALU_SUB]  = inst_sub_w | inst_beq | inst_bne;
    alu_op[ALU_SLT]  = inst_slt | inst_slti | inst_blt | inst_bge;
    alu_op[ALU_SLTU] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
    alu_op[ALU_AND]  = inst_and | inst_andi;
    alu_op[ALU_NOR]  = inst_nor;
    alu_op[ALU_OR]   = inst_or | inst_ori;
    alu_op[ALU_XOR]  = inst_xor | inst_xori;
    alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
    alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
    alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
    alu_op[ALU_LUI]  = inst_lu12i_w;
  end

  assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
  assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
  assign need_ui12 = inst_andi | inst_ori | inst_xori;
  assign need_si16 = inst_jirl | is_cond_br;
  assign need_i20  = inst_lu12i_w | inst_pcaddu;
  assign need_si26 = inst_b | inst_bl;

  // ui5 takes the value read through the rk port.
  always_comb begin
    if (need_ui5) begin
      imm = rdata_b;
    end else if (need_i20) begin
      imm = {i20, 12'b0};
    end else if (need_si26) begin
      imm = {{6{i26[25]}}, i26};
    end else if (need_si16) begin
      imm = {{16{i16[15]}}, i16};
    end else if (need_si12 || !need_ui12) begin
      imm = {{20{i12[11]}}, i12};
    end else begin
      imm = {20'b0, i12};
    end
  end

  assign src_reg_is_rd = is_cond_br | inst_st_w;
  assign src1_is_pc    = inst_jirl | inst_bl | inst_pcaddu;
  assign src2_is_4     = inst_jirl | inst_bl;
  assign src2_is_imm   = need_ui5 | need_si12 | need_ui12 | need_i20;
  assign gr_we         = !(inst_st_w | is_cond_br | inst_b);
  assign may_jump      = is_cond_br | inst_jirl | inst_b | inst_bl;

  assign raddr_a = ins.ri.rj;
  assign raddr_b = src_reg_is_rd ? ins.ri.rd : ins.r3.rk;

  assign op.alu_op       = alu_op;
  assign op.may_jump     = may_jump;
  assign op.use_rj_value = inst_jirl;
  assign op.use_less     = inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign op.need_less    = inst_blt | inst_bltu;
  assign op.use_zero     = inst_beq | inst_bne;
  assign op.need_zero    = inst_beq;
  assign op.src1_is_pc   = src1_is_pc;
  assign op.src2_is_imm  = src2_is_imm;
  assign op.src2_is_4    = src2_is_4;
  assign op.gr_we        = gr_we;
  assign op.mem_we       = inst_st_w;
  assign op.res_from_mem = inst_ld_w;
  assign op.dest         = inst_bl ? 5'd1 : ins.ri.rd;
  assign op.imm          = imm;
  assign op.rj_value     = rdata_a;
  assign op.rkd_value    = rdata_b;
  assign op.pc           = slot.pc;
  assign op.pred_jump    = slot.pred_jump;

  assign hazard.writes_reg = gr_we;
  assign hazard.dest       = op.dest;
  assign hazard.reads_rj   = !(inst_b | inst_bl | inst_lu12i_w | inst_pcaddu);
  assign hazard.rj         = raddr_a;
  assign hazard.reads_rkd  = is_3r_reg | src_reg_is_rd;
  assign hazard.rkd        = raddr_b;
  assign hazard.may_jump   = may_jump;
  assign hazard.is_ls      = inst_ld_w | inst_st_w;

  // flag table must never select two alu functions at once.
  always_comb begin
    if (slot.valid) begin
      a_alu_onehot: assert final ($onehot0(op.alu_op))
        else $error("alu_op not one-hot: %b", op.alu_op);
    end
  end

endmodule

// File: src/issue_check.sv
`timescale 1ns/1ps

module issue_check
  import decode_pkg::*;
(
  input  hazard_t    hazard0,
  input  hazard_t    hazard1,
  input  logic       slot0_valid,
  input  logic       slot1_valid,
  input  logic       exe_ready,
  output logic       issue0,
  output logic       issue1,
  output logic [1:0] pop
);

  logic writes_nz;
  logic raw_rj;
  logic raw_rkd;
  logic pair_ok;

  assign issue0 = slot0_valid && exe_ready;

  // r0 never holds a result, so writes to it carry no dependency.
  assign writes_nz = hazard0.writes_reg && (hazard0.dest != '0);

  assign raw_rj  = writes_nz && hazard1.reads_rj && (hazard0.dest == hazard1.rj);
  assign raw_rkd = writes_nz && hazard1.reads_rkd && (hazard0.dest == hazard1.rkd);

  // branches stay alone; one memory port only.
  assign pair_ok = !hazard0.may_jump
                && !hazard0.is_ls
                && !hazard1.is_ls
                && !raw_rj
                && !raw_rkd;

  assign issue1 = issue0 && slot1_valid && pair_ok;

  // buffer consumes exactly what issues.
  assign pop = {issue1, issue0};

endmodule

// File: src/issue_reg.sv
`timescale 1ns/1ps

module issue_reg
  import decode_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    flush,
  input  logic    exe_ready,
  input  logic    issue0,
  input  logic    issue1,
  input  exe_op_t op0_in,
  input  exe_op_t op1_in,
  output exe_op_t exe_op0,
  output exe_op_t exe_op1,
  output logic    exe_valid0,
  output logic    exe_valid1
);

  // valid bits. flush wins over a stall.
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      exe_valid0 <= 1'b0;
      exe_valid1 <= 1'b0;
    end else if (exe_ready) begin
      exe_valid0 <= issue0;
      exe_valid1 <= issue1;
    end
  end

  // payload.
  always_ff @(posedge clk) begin
    if (exe_ready) begin
      exe_op0 <= op0_in;
      exe_op1 <= op1_in;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // issue order from the check logic must survive the register.
  a_valid_order: assert property (@(posedge clk) disable iff (!rst_n)
    exe_valid1 |-> exe_valid0)
    else $error("slot 1 valid without slot 0");

  // execute sees the same bundle for every stalled cycle.
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!exe_ready && !flush) |=>
      ($stable(exe_op0) && $stable(exe_op1) && $stable(exe_valid0) && $stable(exe_valid1)))
    else $error("outputs changed across a stall");

endmodule

// File: tests/decode_checker.sv
`timescale 1ns/1ps

module decode_checker
  import decode_pkg::*;
(
  input  logic         clk,
  input  logic         active,
  input  logic [127:0] name,
  input  logic [1:0]   exp_pop,
  input  logic [1:0]   exp_valid,
  input  exe_op_t      exp_op0,
  input  exe_op_t      exp_op1,
  input  logic [1:0]   pop,
  input  logic         exe_valid0,
  input  logic         exe_valid1,
  input  exe_op_t      exe_op0,
  input  exe_op_t      exe_op1,
  output int           checks,
  output int           errors
);

  // expectations of the row whose ops are now registered.
  logic [127:0] prev_name  = "reset";
  logic [1:0]   prev_valid = 2'b00;
  exe_op_t      prev_op0   = '0;
  exe_op_t      prev_op1   = '0;
  int           n_checks   = 0;
  int           n_errors   = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  // branch, operand select and memory controls side by side.
  function automatic logic [9:0] ctrl_bits(input exe_op_t op);
    return {op.use_rj_value, op.use_less, op.need_less, op.use_zero, op.need_zero,
            op.src1_is_pc, op.src2_is_4, op.mem_we, op.res_from_mem, op.pred_jump};
  endfunction

  task automatic compare(input logic [127:0] tname, input string what,
                         input word_t exp, input word_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] %0s %0s: expected %h, actual %h", tname, what, exp, act);
    end
  endtask

  task automatic compare_op(input logic [127:0] tname, input string slot,
                            input exe_op_t exp, input exe_op_t act);
    compare(tname, {slot, ".alu_op"}, word_t'(exp.alu_op), word_t'(act.alu_op));
    compare(tname, {slot, ".dest"}, word_t'(exp.dest), word_t'(act.dest));
    compare(tname, {slot, ".rj_value"}, exp.rj_value, act.rj_value);
    compare(tname, {slot, ".rkd_value"}, exp.rkd_value, act.rkd_value);
    compare(tname, {slot, ".gr_we"}, word_t'(exp.gr_we), word_t'(act.gr_we));
    compare(tname, {slot, ".may_jump"}, word_t'(exp.may_jump), word_t'(act.may_jump));
    compare(tname, {slot, ".src2_is_imm"}, word_t'(exp.src2_is_imm),
            word_t'(act.src2_is_imm));
    compare(tname, {slot, ".ctrl"}, word_t'(ctrl_bits(exp)), word_t'(ctrl_bits(act)));
    compare(tname, {slot, ".pc"}, exp.pc, act.pc);
    // imm only means something for immediate forms and branch offsets.
    if (exp.src2_is_imm || exp.may_jump) begin
      compare(tname, {slot, ".imm"}, exp.imm, act.imm);
    end
  endtask

  always @(posedge clk) begin
    if (active) begin
      compare(prev_name, "exe_valid", word_t'(prev_valid),
              word_t'({exe_valid1, exe_valid0}));
      if (prev_valid[0]) begin
        compare_op(prev_name, "op0", prev_op0, exe_op0);
      end
      if (prev_valid[1]) begin
        compare_op(prev_name, "op1", prev_op1, exe_op1);
      end
      // pop is combinational, so it belongs to this row.
      compare(name, "pop", word_t'(exp_pop), word_t'(pop));
      prev_name  = name;
      prev_valid = exp_valid;
      prev_op0   = exp_op0;
      prev_op1   = exp_op1;
    end
  end

endmodule

// File: tests/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage
  import decode_pkg::*;
();

  localparam int    CLK_PERIOD = 8;
  localparam int    MAX_ROWS   = 32;
  localparam word_t RF_SCALE   = 32'h0101_0101;

  // instruction kinds the table can encode.
  localparam int K_ADD   = 0;
  localparam int K_SUB   = 1;
  localparam int K_XOR   = 2;
  localparam int K_SLTU  = 3;
  localparam int K_ADDI  = 4;
  localparam int K_ANDI  = 5;
  localparam int K_SLLI  = 6;
  localparam int K_LU12I = 7;
  localparam int K_BEQ   = 8;
  localparam int K_BL    = 9;
  localparam int K_LD    = 10;
  localparam int K_ST    = 11;

  typedef struct packed {
    logic [127:0] name;
    fetch_slot_t  slot0;
    fetch_slot_t  slot1;
    logic         ready;
    logic         flush;
    logic [1:0]   pop;
    logic [1:0]   valid;
    exe_op_t      op0;
    exe_op_t      op1;
  } row_t;

  logic        clk;
  logic        rst_n;
  fetch_slot_t fetch_slot0;
  fetch_slot_t fetch_slot1;
  logic        exe_ready;
  logic        flush;
  logic [1:0]  pop;
  reg_addr_t   rf_raddr0;
  reg_addr_t   rf_raddr1;
  reg_addr_t   rf_raddr2;
  reg_addr_t   rf_raddr3;
  word_t       rf_rdata0;
  word_t       rf_rdata1;
  word_t       rf_rdata2;
  word_t       rf_rdata3;
  exe_op_t     exe_op0;
  exe_op_t     exe_op1;
  logic        exe_valid0;
  logic        exe_valid1;

  row_t   rows [MAX_ROWS];
  row_t   draft;
  row_t   cur;
  int     n_rows;
  logic   active;
  integer seed;
  int     checks;
  int     errors;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // register file model.
  assign rf_rdata0 = word_t'(rf_raddr0) * RF_SCALE;
  assign rf_rdata1 = word_t'(rf_raddr1) * RF_SCALE;
  assign rf_rdata2 = word_t'(rf_raddr2) * RF_SCALE;
  assign rf_rdata3 = word_t'(rf_raddr3) * RF_SCALE;

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_slot0 (fetch_slot0),
    .fetch_slot1 (fetch_slot1),
    .pop         (pop),
    .rf_raddr0   (rf_raddr0),
    .rf_raddr1   (rf_raddr1),
    .rf_raddr2   (rf_raddr2),
    .rf_raddr3   (rf_raddr3),
    .rf_rdata0   (rf_rdata0),
    .rf_rdata1   (rf_rdata1),
    .rf_rdata2   (rf_rdata2),
    .rf_rdata3   (rf_rdata3),
    .exe_op0     (exe_op0),
    .exe_op1     (exe_op1),
    .exe_valid0  (exe_valid0),
    .exe_valid1  (exe_valid1),
    .exe_ready   (exe_ready),
    .flush       (flush)
  );

  decode_checker u_check (
    .clk        (clk),
    .active     (active),
    .name       (cur.name),
    .exp_pop    (cur.pop),
    .exp_valid  (cur.valid),
    .exp_op0    (cur.op0),
    .exp_op1    (cur.op1),
    .pop        (pop),
    .exe_valid0 (exe_valid0),
    .exe_valid1 (exe_valid1),
    .exe_op0    (exe_op0),
    .exe_op1    (exe_op1),
    .checks     (checks),
    .errors     (errors)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // table construction.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic reg_addr_t pick_reg(input int base);
    int r;
    r = base + ($random(seed) & 7);
    return reg_addr_t'(r);
  endfunction

  task automatic put_slot(input int which, input int kind, input reg_addr_t rd,
                          input reg_addr_t rj, input reg_addr_t rk,
                          input logic [25:0] imm);
    fetch_slot_t s;
    exe_op_t     e;
    word_t       w;
    logic        rd_src;
    w       = '0;
    e       = '0;
    rd_src  = 1'b0;
    e.gr_we = 1'b1;
    e.dest  = rd;
    case (kind)
      K_ADD: begin
        w = {FN_ADD_W, rk, rj, rd};
        e.alu_op[ALU_ADD] = 1'b1;
      end
      K_SUB: begin
        w = {FN_SUB_W, rk, rj, rd};
        e.alu_op[ALU_SUB] = 1'b1;
      end
      K_XOR: begin
        w = {FN_XOR, rk, rj, rd};
        e.alu_op[ALU_XOR] = 1'b1;
      end
      K_SLTU: begin
        w = {FN_SLTU, rk, rj, rd};
        e.alu_op[ALU_SLTU] = 1'b1;
      end
      K_ADDI: begin
        w = {OPC_ALU, MIN_ADDI, imm[11:0], rj, rd};
        e.alu_op[ALU_ADD] = 1'b1;
        e.imm = {{20{imm[11]}}, imm[11:0]};
        e.src2_is_imm = 1'b1;
      end
      K_ANDI: begin
        w = {OPC_ALU, MIN_ANDI, imm[11:0], rj, rd};
        e.alu_op[ALU_AND] = 1'b1;
        e.imm = {20'b0, imm[11:0]};
        e.src2_is_imm = 1'b1;
      end
      K_SLLI: begin
        w = {FN_SLLI_W, imm[4:0], rj, rd};
        e.alu_op[ALU_SLL] = 1'b1;
        e.imm = word_t'(imm[4:0]) * RF_SCALE;
        e.src2_is_imm = 1'b1;
      end
      K_LU12I: begin
        w = {OPC_LU12I, 1'b0, imm[19:0], rd};
        e.alu_op[ALU_LUI] = 1'b1;
        e.imm = {imm[19:0], 12'b0};
        e.src2_is_imm = 1'b1;
      end
      K_BEQ: begin
        w = {OPC_BEQ, imm[15:0], rj, rd};
        e.alu_op[ALU_SUB] = 1'b1;
        e.imm = {{16{imm[15]}}, imm[15:0]};
        e.may_jump = 1'b1;
        e.use_zero = 1'b1;
        e.need_zero = 1'b1;
        e.gr_we = 1'b0;
        rd_src = 1'b1;
      end
      K_BL: begin
        w = {OPC_BL, imm[15:0], imm[25:16]};
        e.alu_op[ALU_ADD] = 1'b1;
        e.imm = {{6{imm[25]}}, imm};
        e.may_jump = 1'b1;
        e.src1_is_pc = 1'b1;
        e.src2_is_4 = 1'b1;
        e.dest = 5'd1;
      end
      K_LD: begin
        w = {OPC_MEM, MIN_LD_W, imm[11:0], rj, rd};
        e.alu_op[ALU_ADD] = 1'b1;
        e.imm = {{20{imm[11]}}, imm[11:0]};
        e.src2_is_imm = 1'b1;
        e.res_from_mem = 1'b1;
      end
      K_ST: begin
        w = {OPC_MEM, MIN_ST_W, imm[11:0], rj, rd};
        e.alu_op[ALU_ADD] = 1'b1;
        e.imm = {{20{imm[11]}}, imm[11:0]};
        e.src2_is_imm = 1'b1;
        e.mem_we = 1'b1;
        e.gr_we = 1'b0;
        rd_src = 1'b1;
      end
      default: ;
    endcase
    // second read port is rd for branches and stores, rk otherwise.
    e.rj_value  = word_t'(w[9:5]) * RF_SCALE;
    e.rkd_value = word_t'(rd_src ? w[4:0] : w[14:10]) * RF_SCALE;
    s       = '0;
    s.valid = 1'b1;
    s.instr = w;
    // pc and prediction differ per row and per slot.
    s.pc        = 32'h1c00_0000 + word_t'(n_rows * 8 + which * 4);
    s.pred_jump = ((n_rows + which) % 2) == 1;
    e.pc        = s.pc;
    e.pred_jump = s.pred_jump;
    if (which == 0) begin
      draft.slot0 = s;
      draft.op0   = e;
    end else begin
      draft.slot1 = s;
      draft.op1   = e;
    end
  endtask

  task automatic idle_slots();
    draft.slot0 = '0;
    draft.slot1 = '0;
    draft.op0   = '0;
    draft.op1   = '0;
  endtask

  task automatic push_row(input logic [127:0] name, input logic ready, input logic fl,
                          input logic [1:0] exp_pop, input logic [1:0] exp_valid);
    draft.name   = name;
    draft.ready  = ready;
    draft.flush  = fl;
    draft.pop    = exp_pop;
    draft.valid  = exp_valid;
    rows[n_rows] = draft;
    // a stalled cycle shows the previous bundle again.
    if (!ready && n_rows > 0) begin
      rows[n_rows].valid = rows[n_rows - 1].valid;
      rows[n_rows].op0   = rows[n_rows - 1].op0;
      rows[n_rows].op1   = rows[n_rows - 1].op1;
    end
    n_rows++;
  endtask

  task automatic build_table();
    reg_addr_t x;
    idle_slots();
    push_row("after_reset", 1'b1, 1'b0, 2'b00, 2'b00);
    put_slot(0, K_ADD, pick_reg(24), pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_SUB, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("add_sub_dual", 1'b1, 1'b0, 2'b11, 2'b11);
    put_slot(0, K_XOR, pick_reg(24), pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_SLTU, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("xor_sltu_dual", 1'b1, 1'b0, 2'b11, 2'b11);
    put_slot(0, K_ADDI, pick_reg(24), pick_reg(1), 5'd0, 26'h0000f9c);
    put_slot(1, K_ANDI, pick_reg(16), pick_reg(8), 5'd0, 26'h00008a5);
    push_row("addi_andi_ext", 1'b1, 1'b0, 2'b11, 2'b11);
    put_slot(0, K_SLLI, pick_reg(24), pick_reg(1), 5'd0, 26'h0000007);
    put_slot(1, K_LU12I, pick_reg(16), 5'd0, 5'd0, 26'h00abcde);
    push_row("slli_lu12i", 1'b1, 1'b0, 2'b11, 2'b11);
    put_slot(0, K_BEQ, pick_reg(1), pick_reg(1), 5'd0, 26'h000fff0);
    put_slot(1, K_ADD, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("beq_alone", 1'b1, 1'b0, 2'b01, 2'b01);
    put_slot(0, K_BL, 5'd0, 5'd0, 5'd0, 26'h2000040);
    put_slot(1, K_ADD, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("bl_alone", 1'b1, 1'b0, 2'b01, 2'b01);
    x = pick_reg(24);
    put_slot(0, K_ADD, x, pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_SUB, pick_reg(16), x, pick_reg(8), '0);
    push_row("raw_rj_single", 1'b1, 1'b0, 2'b01, 2'b01);
    x = pick_reg(24);
    put_slot(0, K_ADD, x, pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_BEQ, x, pick_reg(8), 5'd0, 26'h0000040);
    push_row("raw_rkd_single", 1'b1, 1'b0, 2'b01, 2'b01);
    put_slot(0, K_LD, pick_reg(24), pick_reg(1), 5'd0, 26'h0000010);
    put_slot(1, K_ADD, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("ld_single", 1'b1, 1'b0, 2'b01, 2'b01);
    put_slot(0, K_ADD, pick_reg(24), pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_ST, pick_reg(8), pick_reg(8), 5'd0, 26'h00007fc);
    push_row("st_single", 1'b1, 1'b0, 2'b01, 2'b01);
    put_slot(0, K_ADD, 5'd0, pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_SUB, pick_reg(16), 5'd0, 5'd0, '0);
    push_row("r0_no_block", 1'b1, 1'b0, 2'b11, 2'b11);
    put_slot(0, K_XOR, pick_reg(24), pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_ADD, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("stall_hold", 1'b0, 1'b0, 2'b00, 2'b00);
    push_row("stall_release", 1'b1, 1'b0, 2'b11, 2'b11);
    put_slot(0, K_ADD, pick_reg(24), pick_reg(1), pick_reg(1), '0);
    put_slot(1, K_SUB, pick_reg(16), pick_reg(8), pick_reg(8), '0);
    push_row("flush_clear", 1'b1, 1'b1, 2'b11, 2'b00);
    idle_slots();
    push_row("drain", 1'b1, 1'b0, 2'b00, 2'b00);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // run.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst_n       = 1'b0;
    fetch_slot0 = '0;
    fetch_slot1 = '0;
    exe_ready   = 1'b1;
    flush       = 1'b0;
    active      = 1'b0;
    cur         = '0;
    draft       = '0;
    n_rows      = 0;
    seed        = 32'h768c_fc60;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      cur         = rows[i];
      fetch_slot0 = cur.slot0;
      fetch_slot1 = cur.slot1;
      exe_ready   = cur.ready;
      flush       = cur.flush;
      active      = 1'b1;
      @(posedge clk);
      #1;
    end
    active = 1'b0;
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog, four cycles per row plus margin.
  initial begin
    wait (active);
    #(n_rows * 4 * CLK_PERIOD + 200);
    $display("watchdog expired: the stimulus table did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: vlog.f
src/decode_pkg.sv
src/instr_decoder.sv
src/issue_check.sv
src/issue_reg.sv
src/decode_stage.sv
tests/decode_checker.sv
tests/tb_decode_stage.sv
